/* dma_ctrl_top.f */
verilog/dma_ctrl_pkg.sv
verilog/ctrl_reg_decoder.sv
verilog/desc_channel.sv
verilog/tlp_counters.sv
verilog/error_pulse_merge.sv
verilog/dma_ctrl_top.sv
tb/dma_ctrl_tb.sv

/* Makefile */
# Verilator build and run of the DMA control testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= dma_ctrl_tb
FILELIST  ?= dma_ctrl_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/dma_ctrl_tb.sv */
// table-driven testbench for dma_ctrl_top with one register request at a time
// the DMA engine and the status source are modeled here
// error pulses stay below saturation of the pending count
`timescale 1ns/1ps

module dma_ctrl_tb;

    localparam int ERR_SOURCES = 3;

    localparam logic [2:0] OP_WR         = 3'd0;
    localparam logic [2:0] OP_RD         = 3'd1;
    localparam logic [2:0] OP_RD_CNT     = 3'd2;
    localparam logic [2:0] OP_DESC       = 3'd3;
    localparam logic [2:0] OP_STATUS     = 3'd4;
    localparam logic [2:0] OP_STATUS_CHK = 3'd5;
    localparam logic [2:0] OP_TAPS       = 3'd6;
    localparam logic [2:0] OP_ERRS       = 3'd7;

    typedef struct packed {
        logic [2:0]  op;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic [15:0]            wr_addr;
    logic [31:0]            wr_data;
    logic                   wr_valid;
    logic                   wr_ready;
    logic                   wr_resp_valid;
    logic                   wr_resp_ready;
    logic [15:0]            rd_addr;
    logic                   rd_valid;
    logic                   rd_ready;
    logic [31:0]            rd_data;
    logic                   rd_resp_valid;
    logic                   rd_resp_ready;
    logic [63:0]            rd_desc_pcie_addr;
    logic [31:0]            rd_desc_local_addr;
    logic [15:0]            rd_desc_len;
    logic [7:0]             rd_desc_tag;
    logic                   rd_desc_valid;
    logic                   rd_desc_ready;
    logic [7:0]             rd_status_tag;
    logic                   rd_status_valid;
    logic                   rd_status_ready;
    logic [63:0]            wr_desc_pcie_addr;
    logic [31:0]            wr_desc_local_addr;
    logic [15:0]            wr_desc_len;
    logic [7:0]             wr_desc_tag;
    logic                   wr_desc_valid;
    logic                   wr_desc_ready;
    logic [7:0]             wr_status_tag;
    logic                   wr_status_valid;
    logic                   wr_status_ready;
    logic                   dma_enable;
    logic                   irq;
    logic [3:0]             mon_valid;
    logic [3:0]             mon_ready;
    logic [3:0]             mon_last;
    logic [ERR_SOURCES-1:0] err_cor_in;
    logic [ERR_SOURCES-1:0] err_uncor_in;
    logic                   err_cor;
    logic                   err_uncor;

    row_t         rows[$];
    int           seed;
    int           cycle_count;
    int           cycle_limit;
    int           exp_cnt [4];
    int           exp_cor;
    int           exp_uncor;
    int           seen_cor;
    int           seen_uncor;
    int           wr_pops;
    int           rd_pops;
    // expected descriptor per channel as {pcie, local, len, tag}
    logic [119:0] exp_desc [2];

    dma_ctrl_top #(
        .ERR_SOURCES     (ERR_SOURCES),
        .ERR_COUNT_WIDTH (4)
    ) i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // status source model drops valid once the pop is seen
    always @(negedge clk) begin
        if (!rst) begin
            seen_cor   += int'(err_cor);
            seen_uncor += int'(err_uncor);
            rd_pops    += int'(rd_status_ready);
            if (wr_status_ready) begin
                wr_pops++;
                wr_status_valid = 1'b0;
            end
        end
    end

    task automatic fail_value(input string what, input logic [127:0] got,
                              input logic [127:0] exp);
        $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic add_row(input logic [2:0] op, input logic [15:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
        row_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    function automatic logic [119:0] desc_fields(input int chan);
        if (chan == 0) begin
            return {rd_desc_pcie_addr, rd_desc_local_addr, rd_desc_len, rd_desc_tag};
        end
        return {wr_desc_pcie_addr, wr_desc_local_addr, wr_desc_len, wr_desc_tag};
    endfunction

    function automatic logic desc_valid_of(input int chan);
        return (chan == 0) ? rd_desc_valid : wr_desc_valid;
    endfunction

    // staged field model built from the channel register map
    task automatic track_field(input logic [15:0] addr, input logic [31:0] data);
        int chan;
        if (addr[15:8] == dma_ctrl_pkg::RD_DESC_BASE[15:8] ||
            addr[15:8] == dma_ctrl_pkg::WR_DESC_BASE[15:8]) begin
            chan = (addr[15:8] == dma_ctrl_pkg::WR_DESC_BASE[15:8]) ? 1 : 0;
            case ({addr[7:2], 2'b00})
                dma_ctrl_pkg::OFS_PCIE_LO: exp_desc[chan][87:56]  = data;
                dma_ctrl_pkg::OFS_PCIE_HI: exp_desc[chan][119:88] = data;
                dma_ctrl_pkg::OFS_LOCAL:   exp_desc[chan][55:24]  = data;
                dma_ctrl_pkg::OFS_LEN:     exp_desc[chan][23:8]   = data[15:0];
                dma_ctrl_pkg::OFS_TAG:     exp_desc[chan][7:0]    = data[7:0];
                default: ;
            endcase
        end
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
        int delay;
        wr_addr  = addr;
        wr_data  = data;
        wr_valid = 1'b1;
        @(negedge clk);
        while (!wr_resp_valid) @(negedge clk);
        wr_valid = 1'b0;
        assert (wr_ready) else fail_value("wr_ready with the response", wr_ready, 1);
        track_field(addr, data);
        delay = $random(seed) & 3;
        repeat (delay) begin
            @(negedge clk);
            assert (wr_resp_valid) else fail_value("wr_resp_valid held", 0, 1);
        end
        wr_resp_ready = 1'b1;
        @(negedge clk);
        wr_resp_ready = 1'b0;
        assert (!wr_resp_valid) else fail_value("wr_resp_valid after ready", 1, 0);
    endtask

    task automatic reg_read(input logic [15:0] addr, output logic [31:0] data);
        int delay;
        rd_addr  = addr;
        rd_valid = 1'b1;
        @(negedge clk);
        while (!rd_resp_valid) @(negedge clk);
        rd_valid = 1'b0;
        assert (rd_ready) else fail_value("rd_ready with the response", rd_ready, 1);
        data  = rd_data;
        delay = $random(seed) & 3;
        repeat (delay) begin
            @(negedge clk);
            assert (rd_resp_valid && rd_data == data)
                else fail_value("read response held", rd_data, data);
        end
        rd_resp_ready = 1'b1;
        @(negedge clk);
        rd_resp_ready = 1'b0;
        assert (!rd_resp_valid) else fail_value("rd_resp_valid after ready", 1, 0);
    endtask

    // engine model holds off ready for a while before taking the descriptor
    task automatic take_desc(input int chan);
        int           delay;
        logic [119:0] held;
        held = desc_fields(chan);
        assert (desc_valid_of(chan)) else fail_value("descriptor valid raised", 0, 1);
        assert (held == exp_desc[chan]) else fail_value("descriptor fields", held, exp_desc[chan]);
        delay = 1 + ($random(seed) & 7);
        repeat (delay) begin
            @(negedge clk);
            assert (desc_valid_of(chan) && desc_fields(chan) == held)
                else fail_value("descriptor stable under back-pressure", desc_fields(chan), held);
            assert (!desc_valid_of(1 - chan)) else fail_value("other channel idle", 1, 0);
        end
        if (chan == 0) rd_desc_ready = 1'b1;
        else wr_desc_ready = 1'b1;
        @(negedge clk);
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        assert (!desc_valid_of(chan)) else fail_value("descriptor valid after handshake", 1, 0);
    endtask

    task automatic drive_taps(input int cycles);
        logic [3:0] hit;
        repeat (cycles) begin
            mon_valid = $random(seed);
            mon_ready = $random(seed);
            mon_last  = $random(seed);
            hit = mon_valid & mon_ready & mon_last;
            for (int i = 0; i < 4; i++) begin
                if (hit[i]) exp_cnt[i]++;
            end
            @(negedge clk);
        end
        mon_valid = '0;
        mon_ready = '0;
        mon_last  = '0;
        @(negedge clk);
    endtask

    // pulses only every fourth cycle keep the pending count small
    task automatic drive_errors(input int cycles);
        int quiet;
        for (int n = 0; n < cycles; n++) begin
            err_cor_in   = '0;
            err_uncor_in = '0;
            if (n % 4 == 0) begin
                err_cor_in   = $random(seed);
                err_uncor_in = $random(seed);
            end
            exp_cor   += $countones(err_cor_in);
            exp_uncor += $countones(err_uncor_in);
            @(negedge clk);
        end
        err_cor_in   = '0;
        err_uncor_in = '0;
        quiet = 0;
        while (quiet < 8) begin
            @(negedge clk);
            if (err_cor || err_uncor) quiet = 0;
            else quiet++;
        end
        assert (seen_cor == exp_cor) else fail_value("err_cor pulses", seen_cor, exp_cor);
        assert (seen_uncor == exp_uncor)
            else fail_value("err_uncor pulses", seen_uncor, exp_uncor);
    endtask

    task automatic build_table();
        for (int i = 0; i < 4; i++) begin
            add_row(OP_RD_CNT, dma_ctrl_pkg::REG_CNT_RQ + 16'(4 * i), i, 0);
        end
        add_row(OP_RD, dma_ctrl_pkg::REG_ENABLE, 0, 32'h0);
        add_row(OP_WR, dma_ctrl_pkg::REG_ENABLE, 32'h1, 0);
        add_row(OP_RD, dma_ctrl_pkg::REG_ENABLE, 0, 32'h1);
        add_row(OP_RD, 16'h0002, 0, 32'h1);
        add_row(OP_RD, 16'h0300, 0, 32'h0);
        add_row(OP_WR, 16'h0300, 32'hdead_beef, 0);
        add_row(OP_RD, 16'h0300, 0, 32'h0);
        add_row(OP_WR, 16'h0100, 32'h1234_5678, 0);
        add_row(OP_WR, 16'h0104, 32'h0000_00ab, 0);
        add_row(OP_WR, 16'h0108, 32'h0000_4000, 0);
        add_row(OP_WR, 16'h0110, 32'h0000_0200, 0);
        add_row(OP_WR, 16'h0114, 32'h0000_0011, 0);
        add_row(OP_DESC, 0, 0, 0);
        add_row(OP_WR, 16'h0200, 32'h8765_4320, 0);
        add_row(OP_WR, 16'h0204, 32'h0000_0cd0, 0);
        add_row(OP_WR, 16'h0208, 32'h0001_8000, 0);
        add_row(OP_WR, 16'h0210, 32'h0000_0080, 0);
        add_row(OP_WR, 16'h0214, 32'h0000_00c3, 0);
        add_row(OP_DESC, 0, 1, 0);
        add_row(OP_STATUS, 0, 32'h5a, 0);
        // read status idle, tag still visible in the low byte
        add_row(OP_RD, 16'h0118, 0, 32'h0000_003c);
        add_row(OP_RD, 16'h0218, 0, 32'h8000_005a);
        add_row(OP_RD, 16'h0218, 0, 32'h0000_005a);
        add_row(OP_STATUS_CHK, 0, 0, 0);
        add_row(OP_TAPS, 0, 200, 0);
        for (int i = 0; i < 4; i++) begin
            add_row(OP_RD_CNT, dma_ctrl_pkg::REG_CNT_RQ + 16'(4 * i), i, 0);
        end
        add_row(OP_ERRS, 0, 300, 0);
    endtask

    initial begin
        logic [31:0] got;
        seed = 32'hdedc320b;
        clk = 1'b0;
        rst = 1'b1;
        wr_addr = '0;
        wr_data = '0;
        wr_valid = 1'b0;
        wr_resp_ready = 1'b0;
        rd_addr = '0;
        rd_valid = 1'b0;
        rd_resp_ready = 1'b0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status_tag = 8'h3c;
        rd_status_valid = 1'b0;
        wr_status_tag = '0;
        wr_status_valid = 1'b0;
        mon_valid = '0;
        mon_ready = '0;
        mon_last = '0;
        err_cor_in = '0;
        err_uncor_in = '0;
        build_table();
        cycle_limit = rows.size() * 40 + 20;
        foreach (rows[k]) begin
            if (rows[k].op == OP_TAPS || rows[k].op == OP_ERRS) begin
                cycle_limit += rows[k].data;
            end
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert ({wr_ready, wr_resp_valid, rd_ready, rd_resp_valid, rd_desc_valid,
                 wr_desc_valid, rd_status_ready, wr_status_ready, dma_enable,
                 err_cor, err_uncor} == '0)
            else fail_value("outputs after reset", 1, 0);

        foreach (rows[k]) begin
            case (rows[k].op)
                OP_WR: reg_write(rows[k].addr, rows[k].data);
                OP_RD: begin
                    reg_read(rows[k].addr, got);
                    assert (got == rows[k].exp) else fail_value("read data", got, rows[k].exp);
                    if (rows[k].addr == dma_ctrl_pkg::REG_ENABLE) begin
                        assert (dma_enable == rows[k].exp[0])
                            else fail_value("dma_enable", dma_enable, rows[k].exp[0]);
                    end
                end
                OP_RD_CNT: begin
                    reg_read(rows[k].addr, got);
                    assert (got == exp_cnt[rows[k].data])
                        else fail_value("packet counter", got, exp_cnt[rows[k].data]);
                end
                OP_DESC: take_desc(rows[k].data);
                OP_STATUS: begin
                    wr_status_tag   = rows[k].data[7:0];
                    wr_status_valid = 1'b1;
                    @(negedge clk);
                    assert (irq) else fail_value("irq with status pending", irq, 1);
                end
                OP_STATUS_CHK: begin
                    assert (wr_pops == 1) else fail_value("wr_status_ready pulses", wr_pops, 1);
                    assert (rd_pops == 0) else fail_value("rd_status_ready pulses", rd_pops, 0);
                    assert (!irq) else fail_value("irq after pop", irq, 0);
                end
                OP_TAPS: drive_taps(rows[k].data);
                default: drive_errors(rows[k].data);
            endcase
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* verilog/dma_ctrl_top.sv */
// control and status block of the PCIe DMA test design
// the DMA engine sits outside; its descriptor and status ports are brought out here
`timescale 1ns/1ps

module dma_ctrl_top #(
    parameter int ERR_SOURCES     = 3,
    parameter int ERR_COUNT_WIDTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,

    input  dma_ctrl_pkg::reg_addr_t   wr_addr,
    input  dma_ctrl_pkg::reg_data_t   wr_data,
    input  logic                      wr_valid,
    output logic                      wr_ready,
    output logic                      wr_resp_valid,
    input  logic                      wr_resp_ready,
    input  dma_ctrl_pkg::reg_addr_t   rd_addr,
    input  logic                      rd_valid,
    output logic                      rd_ready,
    output dma_ctrl_pkg::reg_data_t   rd_data,
    output logic                      rd_resp_valid,
    input  logic                      rd_resp_ready,

    output dma_ctrl_pkg::pcie_addr_t  rd_desc_pcie_addr,
    output dma_ctrl_pkg::local_addr_t rd_desc_local_addr,
    output dma_ctrl_pkg::dma_len_t    rd_desc_len,
    output dma_ctrl_pkg::dma_tag_t    rd_desc_tag,
    output logic                      rd_desc_valid,
    input  logic                      rd_desc_ready,
    input  dma_ctrl_pkg::dma_tag_t    rd_status_tag,
    input  logic                      rd_status_valid,
    output logic                      rd_status_ready,

    output dma_ctrl_pkg::pcie_addr_t  wr_desc_pcie_addr,
    output dma_ctrl_pkg::local_addr_t wr_desc_local_addr,
    output dma_ctrl_pkg::dma_len_t    wr_desc_len,
    output dma_ctrl_pkg::dma_tag_t    wr_desc_tag,
    output logic                      wr_desc_valid,
    input  logic                      wr_desc_ready,
    input  dma_ctrl_pkg::dma_tag_t    wr_status_tag,
    input  logic                      wr_status_valid,
    output logic                      wr_status_ready,

    output logic                      dma_enable,
    output logic                      irq,

    input  logic [3:0]                mon_valid,
    input  logic [3:0]                mon_ready,
    input  logic [3:0]                mon_last,

    input  logic [ERR_SOURCES-1:0]    err_cor_in,
    input  logic [ERR_SOURCES-1:0]    err_uncor_in,
    output logic                      err_cor,
    output logic                      err_uncor
);

    logic                     rd_field_we;
    logic                     wr_field_we;
    dma_ctrl_pkg::field_sel_t field_sel;
    dma_ctrl_pkg::reg_data_t  field_data;
    logic                     rd_status_pop;
    logic                     wr_status_pop;
    dma_ctrl_pkg::pkt_count_t cnt_rq;
    dma_ctrl_pkg::pkt_count_t cnt_rc;
    dma_ctrl_pkg::pkt_count_t cnt_cq;
    dma_ctrl_pkg::pkt_count_t cnt_cc;

    ctrl_reg_decoder u_decoder (
        .clk             (clk),
        .rst             (rst),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .wr_valid        (wr_valid),
        .wr_ready        (wr_ready),
        .wr_resp_valid   (wr_resp_valid),
        .wr_resp_ready   (wr_resp_ready),
        .rd_addr         (rd_addr),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .rd_data         (rd_data),
        .rd_resp_valid   (rd_resp_valid),
        .rd_resp_ready   (rd_resp_ready),
        .dma_enable      (dma_enable),
        .irq             (irq),
        .rd_field_we     (rd_field_we),
        .wr_field_we     (wr_field_we),
        .field_sel       (field_sel),
        .field_data      (field_data),
        .rd_status_tag   (rd_status_tag),
        .wr_status_tag   (wr_status_tag),
        .rd_status_valid (rd_status_valid),
        .wr_status_valid (wr_status_valid),
        .rd_status_pop   (rd_status_pop),
        .wr_status_pop   (wr_status_pop),
        .cnt_rq          (cnt_rq),
        .cnt_rc          (cnt_rc),
        .cnt_cq          (cnt_cq),
        .cnt_cc          (cnt_cc)
    );

    desc_channel u_rd_desc (
        .clk             (clk),
        .rst             (rst),
        .field_we        (rd_field_we),
        .field_sel       (field_sel),
        .field_data      (field_data),
        .desc_pcie_addr  (rd_desc_pcie_addr),
        .desc_local_addr (rd_desc_local_addr),
        .desc_len        (rd_desc_len),
        .desc_tag        (rd_desc_tag),
        .desc_valid      (rd_desc_valid),
        .desc_ready      (rd_desc_ready),
        .status_pop      (rd_status_pop),
        .status_ready    (rd_status_ready)
    );

    desc_channel u_wr_desc (
        .clk             (clk),
        .rst             (rst),
        .field_we        (wr_field_we),
        .field_sel       (field_sel),
        .field_data      (field_data),
        .desc_pcie_addr  (wr_desc_pcie_addr),
        .desc_local_addr (wr_desc_local_addr),
        .desc_len        (wr_desc_len),
        .desc_tag        (wr_desc_tag),
        .desc_valid      (wr_desc_valid),
        .desc_ready      (wr_desc_ready),
        .status_pop      (wr_status_pop),
        .status_ready    (wr_status_ready)
    );

    tlp_counters u_counters (
        .clk       (clk),
        .rst       (rst),
        .mon_valid (mon_valid),
        .mon_ready (mon_ready),
        .mon_last  (mon_last),
        .cnt_rq    (cnt_rq),
        .cnt_rc    (cnt_rc),
        .cnt_cq    (cnt_cq),
        .cnt_cc    (cnt_cc)
    );

    error_pulse_merge #(
        .ERR_SOURCES     (ERR_SOURCES),
        .ERR_COUNT_WIDTH (ERR_COUNT_WIDTH)
    ) u_err_cor (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_cor_in),
        .pulse_out (err_cor)
    );

    error_pulse_merge #(
        .ERR_SOURCES     (ERR_SOURCES),
        .ERR_COUNT_WIDTH (ERR_COUNT_WIDTH)
    ) u_err_uncor (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_uncor_in),
        .pulse_out (err_uncor)
    );

endmodule

/* verilog/error_pulse_merge.sv */
// merges error pulses into one serial stream, one output cycle per input pulse
// pending count saturates, so pulses beyond 2^ERR_COUNT_WIDTH-1 are lost
`timescale 1ns/1ps

module error_pulse_merge #(
    parameter int ERR_SOURCES     = 3,
    parameter int ERR_COUNT_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ERR_SOURCES-1:0] pulse_in,
    output logic                   pulse_out
);

    localparam int SUM_WIDTH = ERR_COUNT_WIDTH + $clog2(ERR_SOURCES + 1);
    localparam logic [SUM_WIDTH-1:0] COUNT_MAX = SUM_WIDTH'({ERR_COUNT_WIDTH{1'b1}});

    logic [ERR_COUNT_WIDTH-1:0] count;
    logic [SUM_WIDTH-1:0]       sum;

    // one unit drains per cycle while anything is pending
    always_comb begin
        sum = SUM_WIDTH'(count) - SUM_WIDTH'(count != '0);
        for (int i = 0; i < ERR_SOURCES; i++) begin
            sum = sum + SUM_WIDTH'(pulse_in[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            pulse_out <= 1'b0;
        end else begin
            count     <= (sum > COUNT_MAX) ? COUNT_MAX[ERR_COUNT_WIDTH-1:0]
                                           : sum[ERR_COUNT_WIDTH-1:0];
            pulse_out <= (count != '0);
        end
    end

endmodule

/* verilog/tlp_counters.sv */
// end-of-packet counters for the RQ, RC, CQ and CC links, wrapping at 2^32
`timescale 1ns/1ps

module tlp_counters (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [3:0]               mon_valid,
    input  logic [3:0]               mon_ready,
    input  logic [3:0]               mon_last,

    output dma_ctrl_pkg::pkt_count_t cnt_rq,
    output dma_ctrl_pkg::pkt_count_t cnt_rc,
    output dma_ctrl_pkg::pkt_count_t cnt_cq,
    output dma_ctrl_pkg::pkt_count_t cnt_cc
);

    dma_ctrl_pkg::pkt_count_t cnt [4];
    logic [3:0]               pkt_end;

    assign pkt_end = mon_valid & mon_ready & mon_last;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                cnt[i] <= '0;
            end else if (pkt_end[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign cnt_rq = cnt[dma_ctrl_pkg::LINK_RQ];
    assign cnt_rc = cnt[dma_ctrl_pkg::LINK_RC];
    assign cnt_cq = cnt[dma_ctrl_pkg::LINK_CQ];
    assign cnt_cc = cnt[dma_ctrl_pkg::LINK_CC];

endmodule

/* verilog/desc_channel.sv */
// staging registers for one descriptor direction
// field writes while a descriptor is pending overwrite it in place
`timescale 1ns/1ps

module desc_channel (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      field_we,
    input  dma_ctrl_pkg::field_sel_t  field_sel,
    input  dma_ctrl_pkg::reg_data_t   field_data,

    output dma_ctrl_pkg::pcie_addr_t  desc_pcie_addr,
    output dma_ctrl_pkg::local_addr_t desc_local_addr,
    output dma_ctrl_pkg::dma_len_t    desc_len,
    output dma_ctrl_pkg::dma_tag_t    desc_tag,
    output logic                      desc_valid,
    input  logic                      desc_ready,

    input  logic                      status_pop,
    output logic                      status_ready
);

    logic issue;

    assign issue = field_we && (field_sel == dma_ctrl_pkg::FIELD_TAG);

    always_ff @(posedge clk) begin
        if (field_we) begin
            case (field_sel)
                dma_ctrl_pkg::FIELD_PCIE_LO: begin
                    desc_pcie_addr[31:0] <= field_data;
                end
                dma_ctrl_pkg::FIELD_PCIE_HI: begin
                    desc_pcie_addr[63:32] <= field_data;
                end
                dma_ctrl_pkg::FIELD_LOCAL: begin
                    desc_local_addr <= field_data;
                end
                dma_ctrl_pkg::FIELD_LEN: begin
                    desc_len <= field_data[15:0];
                end
                dma_ctrl_pkg::FIELD_TAG: begin
                    desc_tag <= field_data[7:0];
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid   <= 1'b0;
            status_ready <= 1'b0;
        end else begin
            // a tag write wins over a handshake in the same cycle
            if (issue) begin
                desc_valid <= 1'b1;
            end else if (desc_valid && desc_ready) begin
                desc_valid <= 1'b0;
            end
            status_ready <= status_pop;
        end
    end

endmodule

/* verilog/ctrl_reg_decoder.sv */
// register port of the control block, one outstanding request per channel
// unmapped reads return zero, unmapped writes are dropped; addr bits 1:0 ignored
`timescale 1ns/1ps

module ctrl_reg_decoder (
    input  logic                     clk,
    input  logic                     rst,

    input  dma_ctrl_pkg::reg_addr_t  wr_addr,
    input  dma_ctrl_pkg::reg_data_t  wr_data,
    input  logic                     wr_valid,
    output logic                     wr_ready,
    output logic                     wr_resp_valid,
    input  logic                     wr_resp_ready,
    input  dma_ctrl_pkg::reg_addr_t  rd_addr,
    input  logic                     rd_valid,
    output logic                     rd_ready,
    output dma_ctrl_pkg::reg_data_t  rd_data,
    output logic                     rd_resp_valid,
    input  logic                     rd_resp_ready,

    output logic                     dma_enable,
    output logic                     irq,

    output logic                     rd_field_we,
    output logic                     wr_field_we,
    output dma_ctrl_pkg::field_sel_t field_sel,
    output dma_ctrl_pkg::reg_data_t  field_data,

    input  dma_ctrl_pkg::dma_tag_t   rd_status_tag,
    input  dma_ctrl_pkg::dma_tag_t   wr_status_tag,
    input  logic                     rd_status_valid,
    input  logic                     wr_status_valid,
    output logic                     rd_status_pop,
    output logic                     wr_status_pop,

    input  dma_ctrl_pkg::pkt_count_t cnt_rq,
    input  dma_ctrl_pkg::pkt_count_t cnt_rc,
    input  dma_ctrl_pkg::pkt_count_t cnt_cq,
    input  dma_ctrl_pkg::pkt_count_t cnt_cc
);

    localparam dma_ctrl_pkg::reg_addr_t CHAN_MASK = 16'hFF00;
    localparam dma_ctrl_pkg::reg_addr_t RD_STATUS_ADDR =
        {dma_ctrl_pkg::RD_DESC_BASE[15:8], dma_ctrl_pkg::OFS_STATUS};
    localparam dma_ctrl_pkg::reg_addr_t WR_STATUS_ADDR =
        {dma_ctrl_pkg::WR_DESC_BASE[15:8], dma_ctrl_pkg::OFS_STATUS};

    logic                    wr_accept;
    logic                    rd_accept;
    dma_ctrl_pkg::reg_addr_t wr_word;
    dma_ctrl_pkg::reg_addr_t rd_word;
    logic                    field_hit;
    dma_ctrl_pkg::reg_data_t rd_mux;
    logic                    rd_pop_req;
    logic                    wr_pop_req;

    function automatic dma_ctrl_pkg::reg_data_t status_word(
        input dma_ctrl_pkg::dma_tag_t tag,
        input logic                   pending
    );
        dma_ctrl_pkg::reg_data_t word;
        word = '0;
        word[7:0] = tag;
        word[dma_ctrl_pkg::STATUS_VALID_BIT] = pending;
        return word;
    endfunction

    // a new request waits while its response is still outstanding
    assign wr_accept = wr_valid && !wr_resp_valid;
    assign rd_accept = rd_valid && !rd_resp_valid;

    assign wr_word = {wr_addr[15:2], 2'b00};
    assign rd_word = {rd_addr[15:2], 2'b00};

    always_comb begin
        field_hit = 1'b1;
        field_sel = dma_ctrl_pkg::FIELD_PCIE_LO;
        case (wr_word[7:0])
            dma_ctrl_pkg::OFS_PCIE_LO: field_sel = dma_ctrl_pkg::FIELD_PCIE_LO;
            dma_ctrl_pkg::OFS_PCIE_HI: field_sel = dma_ctrl_pkg::FIELD_PCIE_HI;
            dma_ctrl_pkg::OFS_LOCAL:   field_sel = dma_ctrl_pkg::FIELD_LOCAL;
            dma_ctrl_pkg::OFS_LEN:     field_sel = dma_ctrl_pkg::FIELD_LEN;
            dma_ctrl_pkg::OFS_TAG:     field_sel = dma_ctrl_pkg::FIELD_TAG;
            default:                   field_hit = 1'b0;
        endcase
    end

    assign rd_field_we = wr_accept && field_hit &&
                         ((wr_word & CHAN_MASK) == dma_ctrl_pkg::RD_DESC_BASE);
    assign wr_field_we = wr_accept && field_hit &&
                         ((wr_word & CHAN_MASK) == dma_ctrl_pkg::WR_DESC_BASE);
    assign field_data  = wr_data;

    // readback, status pop only requested when something is pending
    always_comb begin
        rd_mux     = '0;
        rd_pop_req = 1'b0;
        wr_pop_req = 1'b0;
        case (rd_word)
            dma_ctrl_pkg::REG_ENABLE: rd_mux = {31'd0, dma_enable};
            RD_STATUS_ADDR: begin
                rd_mux     = status_word(rd_status_tag, rd_status_valid);
                rd_pop_req = rd_status_valid;
            end
            WR_STATUS_ADDR: begin
                rd_mux     = status_word(wr_status_tag, wr_status_valid);
                wr_pop_req = wr_status_valid;
            end
            dma_ctrl_pkg::REG_CNT_RQ: rd_mux = cnt_rq;
            dma_ctrl_pkg::REG_CNT_RC: rd_mux = cnt_rc;
            dma_ctrl_pkg::REG_CNT_CQ: rd_mux = cnt_cq;
            dma_ctrl_pkg::REG_CNT_CC: rd_mux = cnt_cc;
            default: rd_mux = '0;
        endcase
    end

    assign rd_status_pop = rd_accept && rd_pop_req;
    assign wr_status_pop = rd_accept && wr_pop_req;

    assign irq = rd_status_valid || wr_status_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready      <= 1'b0;
            wr_resp_valid <= 1'b0;
            rd_ready      <= 1'b0;
            rd_resp_valid <= 1'b0;
            dma_enable    <= 1'b0;
        end else begin
            wr_ready <= wr_accept;
            rd_ready <= rd_accept;
            if (wr_accept) begin
                wr_resp_valid <= 1'b1;
            end else if (wr_resp_ready) begin
                wr_resp_valid <= 1'b0;
            end
            if (rd_accept) begin
                rd_resp_valid <= 1'b1;
            end else if (rd_resp_ready) begin
                rd_resp_valid <= 1'b0;
            end
            if (wr_accept && wr_word == dma_ctrl_pkg::REG_ENABLE) begin
                dma_enable <= wr_data[0];
            end
        end
    end

    // read data holds until the response is taken
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_data <= rd_mux;
        end
    end

endmodule

/* verilog/dma_ctrl_pkg.sv */
// widths, register map and descriptor field codes of the DMA control block
// addresses are byte addresses on a 16-bit register window
package dma_ctrl_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [63:0] pcie_addr_t;
    typedef logic [31:0] local_addr_t;
    typedef logic [15:0] dma_len_t;
    typedef logic [7:0]  dma_tag_t;
    typedef logic [31:0] pkt_count_t;
    typedef logic [2:0]  field_sel_t;

    // descriptor fields inside one channel
    localparam field_sel_t FIELD_PCIE_LO = 3'd0;
    localparam field_sel_t FIELD_PCIE_HI = 3'd1;
    localparam field_sel_t FIELD_LOCAL   = 3'd2;
    localparam field_sel_t FIELD_LEN     = 3'd3;
    // tag write also issues the descriptor
    localparam field_sel_t FIELD_TAG     = 3'd4;

    localparam reg_addr_t REG_ENABLE   = 16'h0000;
    localparam reg_addr_t RD_DESC_BASE = 16'h0100;
    localparam reg_addr_t WR_DESC_BASE = 16'h0200;

    // offsets within a channel window
    localparam logic [7:0] OFS_PCIE_LO = 8'h00;
    localparam logic [7:0] OFS_PCIE_HI = 8'h04;
    localparam logic [7:0] OFS_LOCAL   = 8'h08;
    localparam logic [7:0] OFS_LEN     = 8'h10;
    localparam logic [7:0] OFS_TAG     = 8'h14;
    localparam logic [7:0] OFS_STATUS  = 8'h18;

    localparam reg_addr_t REG_CNT_RQ = 16'h0400;
    localparam reg_addr_t REG_CNT_RC = 16'h0404;
    localparam reg_addr_t REG_CNT_CQ = 16'h0408;
    localparam reg_addr_t REG_CNT_CC = 16'h040C;

    // pending flag in a status read
    localparam int STATUS_VALID_BIT = 31;

    // bit positions in the monitor tap vectors
    localparam int LINK_RQ = 0;
    localparam int LINK_RC = 1;
    localparam int LINK_CQ = 2;
    localparam int LINK_CC = 3;

endpackage
